/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = gpuTb
RTL_TOP   = gpuTop
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/gpuTb.sv */
//****************************************
// gpuTb
// random register, fill and scan-out test
// of the fill accelerator against a model
//****************************************
`timescale 1ns/1ps
`default_nettype none

module gpuTb;

    localparam int hDisp    = 16;    // gpuTop defaults
    localparam int vDisp    = 8;
    localparam int hBlank   = 4;
    localparam int vBlank   = 2;
    localparam int pixels   = hDisp * vDisp;
    localparam int lineLen  = hDisp + hBlank;
    localparam int framePer = lineLen * (vDisp + vBlank);
    localparam int hsLimit  = 20;    // cycles allowed for one handshake

    logic               clk;
    logic               rstn;
    logic               awvalid;
    logic               awready;
    logic [31:0]        awaddr;
    logic               wvalid;
    logic               wready;
    gpuPkg::regWordT    wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    logic [31:0]        araddr;
    logic               rvalid;
    logic               rready;
    gpuPkg::regWordT    rdata;
    logic [1:0]         rresp;
    videoPkg::videoOutT video;

    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;
    int                 timeouts;
    int                 cycles;
    logic [31:0]        regModel [0:7];
    gpuPkg::pixelT      fbModel [0:1][0:pixels-1];
    logic               dispModel;

    gpuTop uut
    (
        .clk     (clk),
        .rstn    (rstn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .video   (video)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finishRun;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic noteTimeout(input string what);
        timeouts++;
        $display("Timeout: %s at %0t", what, $time);
    endtask

    // right-shift Galois form, maximal length
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] regAddr(input gpuPkg::regAddrT idx);
        return {27'b0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] strobeMerge(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int t;
        int stall;
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        t = 0;
        @(posedge clk);
        while (!(awready && wready) && t < hsLimit)
        begin
            @(posedge clk);
            t++;
        end
        if (!(awready && wready))
            noteTimeout("write address and data never accepted");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        t = 0;
        @(posedge clk);
        while (!bvalid && t < hsLimit)
        begin
            @(posedge clk);
            t++;
        end
        if (!bvalid)
            noteTimeout("no write response");
        checkVal("bresp", 32'(bresp), 32'h0);
        stall = int'(randBits(2));
        repeat (stall)
        begin
            @(posedge clk);
            checkVal("bvalid", 32'(bvalid), 32'h1);   // held under back-pressure
        end
        bready <= 1'b1;
        @(posedge clk);
        checkVal("bvalid", 32'(bvalid), 32'h1);
        bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, output logic [31:0] data);
        int t;
        int stall;
        arvalid <= 1'b1;
        araddr  <= addr;
        t = 0;
        @(posedge clk);
        while (!arready && t < hsLimit)
        begin
            @(posedge clk);
            t++;
        end
        if (!arready)
            noteTimeout("read address never accepted");
        arvalid <= 1'b0;
        t = 0;
        @(posedge clk);
        while (!rvalid && t < hsLimit)
        begin
            @(posedge clk);
            t++;
        end
        if (!rvalid)
            noteTimeout("no read response");
        data = rdata;
        checkVal("rresp", 32'(rresp), 32'h0);
        stall = int'(randBits(2));
        repeat (stall)
        begin
            @(posedge clk);
            checkVal("rvalid", 32'(rvalid), 32'h1);
            checkVal("rdata", rdata, data);   // must not move while stalled
        end
        rready <= 1'b1;
        @(posedge clk);
        checkVal("rvalid", 32'(rvalid), 32'h1);
        rready <= 1'b0;
    endtask

    task automatic regWrite(input gpuPkg::regAddrT idx, input logic [31:0] data,
                            input logic [3:0] strb);
        axiWrite(regAddr(idx), data, strb);
        if (idx <= gpuPkg::regLen || idx == gpuPkg::regBank)
            regModel[idx] = strobeMerge(regModel[idx], data, strb);
    endtask

    task automatic readCheck(input gpuPkg::regAddrT idx);
        logic [31:0] d;
        axiRead(regAddr(idx), d);
        if (idx == gpuPkg::regStatus)
            checkVal("rdata", d & 32'hFFFF_FFFD, 32'h0);   // bank bit follows frame timing
        else
            checkVal("rdata", d, regModel[idx]);
    endtask

    task automatic waitIdle;
        logic [31:0] d;
        int n;
        n = 0;
        axiRead(regAddr(gpuPkg::regStatus), d);
        while (d[0] && n < 80)
        begin
            axiRead(regAddr(gpuPkg::regStatus), d);
            n++;
        end
        if (d[0])
            noteTimeout("fill engine still busy after status polling");
    endtask

    task automatic setBank(input logic b);
        logic [31:0] d;
        int t0;
        regWrite(gpuPkg::regBank, {31'b0, b}, 4'hF);
        t0 = cycles;
        axiRead(regAddr(gpuPkg::regStatus), d);
        while (d[1] != b && cycles - t0 < framePer + 40)
            axiRead(regAddr(gpuPkg::regStatus), d);
        if (d[1] != b)
        begin
            errors++;
            $display("status never showed bank %0d within a frame period", b);
        end
        dispModel = b;
    endtask

    task automatic waitFrameStart;
        int t;
        t = 0;
        @(posedge clk);
        while (!video.frameStart && t < framePer + 10)
        begin
            @(posedge clk);
            t++;
        end
        if (!video.frameStart)
            noteTimeout("no frameStart in the video stream");
    endtask

    // one whole frame against the front bank, position by position
    task automatic checkFrame;
        int n;
        int h;
        int v;
        logic inArea;
        waitFrameStart();
        for (n = 0; n < framePer; n++)
        begin
            h      = n % lineLen;
            v      = n / lineLen;
            inArea = (h < hDisp) && (v < vDisp);
            checkVal("video.frameStart", 32'(video.frameStart), 32'(n == 0));
            checkVal("video.de", 32'(video.de), 32'(inArea));
            checkVal("video.hsync", 32'(video.hsync), 32'(h >= hDisp));
            checkVal("video.vsync", 32'(video.vsync), 32'(v >= vDisp));
            if (inArea)
                checkVal("video.rgb", 32'(video.rgb), 32'(fbModel[dispModel][v * hDisp + h]));
            else
                checkVal("video.rgb", 32'(video.rgb), 32'h0);
            @(posedge clk);
        end
    endtask

    task automatic modelFill(input int x, input int y, input int len, input gpuPkg::pixelT color);
        int addr;
        int n;
        addr = y * hDisp + x;
        n    = 0;
        while (n < len && addr < pixels)   // clipped at the bank end
        begin
            fbModel[dispModel ? 0 : 1][addr] = color;
            addr++;
            n++;
        end
    endtask

    task automatic runSpan(input int x, input int y, input int len, input gpuPkg::pixelT color,
                           input bit watchFront);
        regWrite(gpuPkg::regXPos, 32'(x), 4'hF);
        regWrite(gpuPkg::regYPos, 32'(y), 4'hF);
        regWrite(gpuPkg::regPixel, 32'(color), 4'hF);
        regWrite(gpuPkg::regLen, 32'(len), 4'hF);
        regWrite(gpuPkg::regCtrl, 32'h1, 4'hF);
        modelFill(x, y, len, color);
        if (watchFront)
            checkFrame();   // front bank must not change while the back fills
        waitIdle();
    endtask

    task automatic droppedStart;
        logic [31:0]   d;
        gpuPkg::pixelT colorA;
        int            x;
        colorA = gpuPkg::pixelT'(randBits(24));
        x      = int'(randBits(4));
        regWrite(gpuPkg::regXPos, 32'(x), 4'hF);
        regWrite(gpuPkg::regYPos, 32'h0, 4'hF);
        regWrite(gpuPkg::regPixel, 32'(colorA), 4'hF);
        regWrite(gpuPkg::regLen, 32'd100, 4'hF);
        regWrite(gpuPkg::regCtrl, 32'h1, 4'hF);
        axiRead(regAddr(gpuPkg::regStatus), d);
        checkVal("status busy", 32'(d[0]), 32'h1);
        regWrite(gpuPkg::regPixel, 32'(~colorA), 4'hF);
        regWrite(gpuPkg::regCtrl, 32'h1, 4'hF);   // lands while busy
        modelFill(x, 0, 100, colorA);
        waitIdle();
    endtask

    initial
    begin
        gpuPkg::regAddrT idx;
        rstn    = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        lfsr      = 32'h02fa_6232;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        dispModel = 1'b0;
        for (int i = 0; i < 8; i++)
            regModel[i] = '0;
        for (int i = 0; i < pixels; i++)
        begin
            fbModel[0][i] = '0;
            fbModel[1][i] = '0;
        end

        repeat (4) @(posedge clk);
        checkVal("handshake and video flags in reset",
                 32'({awready, wready, bvalid, arready, rvalid, video.de, video.frameStart}),
                 32'h0);
        rstn <= 1'b1;
        @(posedge clk);

        // registers after reset, then random strobed writes
        for (int i = 0; i < 8; i++)
            readCheck(gpuPkg::regAddrT'(i));
        repeat (24)
        begin
            idx = gpuPkg::regAddrT'(randBits(3));
            if (idx == gpuPkg::regCtrl)
                idx = 3'd7;   // no fills here
            regWrite(idx, randBits(32), 4'(randBits(4)));
        end
        regWrite(gpuPkg::regStatus, 32'hFFFF_FFFF, 4'hF);   // read-only
        for (int i = 0; i < 8; i++)
            readCheck(gpuPkg::regAddrT'(i));
        setBank(1'b0);

        for (int round = 0; round < 4; round++)
        begin
            for (int s = 0; s < 3; s++)
                runSpan(int'(randBits(4)), int'(randBits(3)), int'(randBits(6)),
                        gpuPkg::pixelT'(randBits(24)), s == 0);
            if (round == 1)
                runSpan(hDisp - 3, vDisp - 1, 20, gpuPkg::pixelT'(randBits(24)), 1'b0);
            if (round == 2)
                runSpan(int'(randBits(4)), vDisp + 1, 5, gpuPkg::pixelT'(randBits(24)), 1'b0);
            setBank(!dispModel);
            waitFrameStart();
            checkFrame();
        end

        droppedStart();
        setBank(!dispModel);
        waitFrameStart();
        checkFrame();

        finishRun();
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/gpuPkg.sv
verilog/videoPkg.sv
verilog/gpuControl.sv
verilog/spanFill.sv
verilog/frameBuffer.sv
verilog/videoScan.sv
verilog/gpuTop.sv
bench/gpuTb.sv

/* verilog/frameBuffer.sv */
//****************************************
// frameBuffer
// two-bank pixel RAM, one write port and
// one registered read port
//****************************************
`timescale 1ns/1ps
`default_nettype none

module frameBuffer
#(
    parameter int hDisp = 16,
    parameter int vDisp = 8
)
(
    input  logic              clk,
    input  gpuPkg::fbWriteT   fbWrite,
    input  logic              rdBank,
    input  gpuPkg::fbAddrT    rdAddr,
    output gpuPkg::pixelT     rdData
);

    localparam int depth = hDisp * vDisp;    // pixels per bank
    localparam int idxW  = $clog2(2 * depth);

    gpuPkg::pixelT   mem [0:2*depth-1];
    logic [idxW-1:0] wrIdx;
    logic [idxW-1:0] rdIdx;

    // bank 1 sits right above bank 0
    assign wrIdx = fbWrite.bank ? idxW'(depth) + idxW'(fbWrite.addr) : idxW'(fbWrite.addr);
    assign rdIdx = rdBank ? idxW'(depth) + idxW'(rdAddr) : idxW'(rdAddr);

    initial
    begin
        for (int i = 0; i < 2 * depth; i++)
            mem[i] = '0;
    end

    always @(posedge clk)
    begin
        if (fbWrite.we)
            mem[wrIdx] <= fbWrite.color;
    end

    always_ff @(posedge clk)
    begin
        rdData <= mem[rdIdx];   // old data on same-address collision
    end

endmodule

`default_nettype wire

/* verilog/gpuControl.sv */
//****************************************
// gpuControl
// AXI4-Lite slave and register file, issues
// fill starts and swaps the displayed bank
//****************************************
`timescale 1ns/1ps
`default_nettype none

module gpuControl
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  gpuPkg::regWordT   wdata,
    input  logic [3:0]        wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [31:0]       araddr,
    output logic              rvalid,
    input  logic              rready,
    output gpuPkg::regWordT   rdata,
    output logic [1:0]        rresp,
    output gpuPkg::fillCmdT   fillCmd,
    output logic              start,
    input  logic              busy,
    input  logic              frameStart,
    output logic              backBank,
    output logic              displayBank
);

    gpuPkg::regWordT xPos;
    gpuPkg::regWordT yPos;
    gpuPkg::regWordT pixel;
    gpuPkg::regWordT len;
    gpuPkg::regWordT bankReq;
    gpuPkg::regWordT rdMux;
    gpuPkg::regAddrT wrIdx;
    gpuPkg::regAddrT rdIdx;
    logic            wrAccept;
    logic            rdAccept;
    logic            wrInMap;
    logic            rdInMap;

    function automatic gpuPkg::regWordT mergeBytes(gpuPkg::regWordT old,
                                                   gpuPkg::regWordT data,
                                                   logic [3:0] strb);
        gpuPkg::regWordT merged;
        merged = old;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                merged[8*i +: 8] = data[8*i +: 8];
        end
        return merged;
    endfunction

    assign wrAccept = awvalid && wvalid && !bvalid;
    assign rdAccept = arvalid && !rvalid;
    assign awready  = wrAccept;
    assign wready   = wrAccept;
    assign arready  = rdAccept;
    assign bresp    = 2'b00;    // always OKAY
    assign rresp    = 2'b00;

    assign wrIdx   = awaddr[4:2];
    assign rdIdx   = araddr[4:2];
    assign wrInMap = (awaddr[31:5] == '0);   // only the first 8 words decode
    assign rdInMap = (araddr[31:5] == '0);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            start       <= 1'b0;
            displayBank <= 1'b0;
            xPos        <= '0;
            yPos        <= '0;
            pixel       <= '0;
            len         <= '0;
            bankReq     <= '0;
        end
        else
        begin
            if (wrAccept)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rdAccept)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            // start pulse, dropped while a span is running
            start <= wrAccept && wrInMap && (wrIdx == gpuPkg::regCtrl) &&
                     wstrb[0] && wdata[0] && !busy;

            if (wrAccept && wrInMap)
            begin
                case (wrIdx)
                    gpuPkg::regXPos:  xPos    <= mergeBytes(xPos, wdata, wstrb);
                    gpuPkg::regYPos:  yPos    <= mergeBytes(yPos, wdata, wstrb);
                    gpuPkg::regPixel: pixel   <= mergeBytes(pixel, wdata, wstrb);
                    gpuPkg::regLen:   len     <= mergeBytes(len, wdata, wstrb);
                    gpuPkg::regBank:  bankReq <= mergeBytes(bankReq, wdata, wstrb);
                    default: ;
                endcase
            end

            if (frameStart)
                displayBank <= bankReq[0];  // swap only between frames
        end
    end

    always_comb
    begin
        rdMux = '0;
        if (rdInMap)
        begin
            case (rdIdx)
                gpuPkg::regXPos:   rdMux = xPos;
                gpuPkg::regYPos:   rdMux = yPos;
                gpuPkg::regPixel:  rdMux = pixel;
                gpuPkg::regLen:    rdMux = len;
                gpuPkg::regStatus: rdMux = {30'b0, displayBank, busy};
                gpuPkg::regBank:   rdMux = bankReq;
                default:           rdMux = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rdAccept)
            rdata <= rdMux;   // held until rready
    end

    always_comb
    begin
        fillCmd.x     = xPos[15:0];
        fillCmd.y     = yPos[15:0];
        fillCmd.color = pixel[23:0];
        fillCmd.len   = len[15:0];
    end

    assign backBank = !displayBank;

endmodule

`default_nettype wire

/* verilog/gpuPkg.sv */
//****************************************
// gpuPkg
// register map, pixel and coordinate types,
// fill command and frame buffer write
//****************************************
`default_nettype none

package gpuPkg;

    typedef logic [23:0] pixelT;    // RGB888, red in high byte
    typedef logic [15:0] coordT;
    typedef logic [15:0] spanLenT;
    typedef logic [15:0] fbAddrT;   // linear index within one bank
    typedef logic [2:0]  regAddrT;  // byte address / 4
    typedef logic [31:0] regWordT;

    localparam regAddrT regXPos   = 3'd0;
    localparam regAddrT regYPos   = 3'd1;
    localparam regAddrT regPixel  = 3'd2;
    localparam regAddrT regLen    = 3'd3;
    localparam regAddrT regCtrl   = 3'd4;  // bit 0 = start
    localparam regAddrT regStatus = 3'd5;  // read-only, busy and displayed bank
    localparam regAddrT regBank   = 3'd6;  // requested display bank

    typedef struct packed {
        coordT   x;
        coordT   y;
        pixelT   color;
        spanLenT len;
    } fillCmdT;

    typedef struct packed {
        logic   we;
        logic   bank;
        fbAddrT addr;
        pixelT  color;
    } fbWriteT;

endpackage

`default_nettype wire

/* verilog/gpuTop.sv */
//****************************************
// gpuTop
// fill accelerator with ping-pong frame
// buffer and video scan-out
//****************************************
`timescale 1ns/1ps
`default_nettype none

module gpuTop
#(
    parameter int hDisp  = 16,
    parameter int vDisp  = 8,
    parameter int hBlank = 4,
    parameter int vBlank = 2
)
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  gpuPkg::regWordT    wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    input  logic               arvalid,
    output logic               arready,
    input  logic [31:0]        araddr,
    output logic               rvalid,
    input  logic               rready,
    output gpuPkg::regWordT    rdata,
    output logic [1:0]         rresp,
    output videoPkg::videoOutT video
);

    gpuPkg::fillCmdT fillCmd;
    gpuPkg::fbWriteT fbWrite;
    gpuPkg::fbAddrT  rdAddr;
    gpuPkg::pixelT   rdData;
    logic            start;
    logic            busy;
    logic            backBank;
    logic            displayBank;
    logic            frameStart;
    logic            rdBank;

    gpuControl uControl
    (
        .clk         (clk),
        .rstn        (rstn),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .fillCmd     (fillCmd),
        .start       (start),
        .busy        (busy),
        .frameStart  (frameStart),
        .backBank    (backBank),
        .displayBank (displayBank)
    );

    spanFill #(.hDisp(hDisp), .vDisp(vDisp)) uFill
    (
        .clk      (clk),
        .rstn     (rstn),
        .fillCmd  (fillCmd),
        .start    (start),
        .backBank (backBank),
        .busy     (busy),
        .fbWrite  (fbWrite)
    );

    frameBuffer #(.hDisp(hDisp), .vDisp(vDisp)) uFb
    (
        .clk     (clk),
        .fbWrite (fbWrite),
        .rdBank  (rdBank),
        .rdAddr  (rdAddr),
        .rdData  (rdData)
    );

    videoScan #(.hDisp(hDisp), .vDisp(vDisp), .hBlank(hBlank), .vBlank(vBlank)) uScan
    (
        .clk         (clk),
        .rstn        (rstn),
        .displayBank (displayBank),
        .frameStart  (frameStart),
        .rdBank      (rdBank),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .video       (video)
    );

endmodule

`default_nettype wire

/* verilog/spanFill.sv */
//****************************************
// spanFill
// walks a span and writes one pixel per clock
//****************************************
`timescale 1ns/1ps
`default_nettype none

module spanFill
#(
    parameter int hDisp = 16,
    parameter int vDisp = 8
)
(
    input  logic              clk,
    input  logic              rstn,
    input  gpuPkg::fillCmdT   fillCmd,
    input  logic              start,
    input  logic              backBank,
    output logic              busy,
    output gpuPkg::fbWriteT   fbWrite
);

    localparam gpuPkg::fbAddrT lastAddr = gpuPkg::fbAddrT'(hDisp * vDisp - 1);

    typedef enum logic {idle, run} stateT;

    stateT           state;
    gpuPkg::fbAddrT  addr;
    gpuPkg::spanLenT remain;
    gpuPkg::pixelT   color;
    logic            bank;
    logic            inRange;
    logic [31:0]     startAddr;
    logic            writeNow;
    logic            lastWrite;

    // wide so an off-screen start cannot wrap into the bank
    assign startAddr = 32'(fillCmd.y) * 32'(hDisp) + 32'(fillCmd.x);

    assign writeNow  = (state == run) && inRange && (remain != '0);
    assign lastWrite = (addr == lastAddr) || (remain == gpuPkg::spanLenT'(1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= idle;
            addr    <= '0;
            remain  <= '0;
            inRange <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (start)
                    begin
                        state   <= run;
                        addr    <= gpuPkg::fbAddrT'(startAddr);
                        remain  <= fillCmd.len;
                        inRange <= (startAddr <= 32'(lastAddr));
                    end
                end
                run:
                begin
                    if (writeNow)
                    begin
                        addr   <= addr + 1'b1;
                        remain <= remain - 1'b1;
                    end
                    if (!writeNow || lastWrite)
                        state <= idle;   // len 0 still costs one cycle
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && (state == idle))
        begin
            color <= fillCmd.color;
            bank  <= backBank;
        end
    end

    assign busy = (state == run);

    always_comb
    begin
        fbWrite.we    = writeNow;
        fbWrite.bank  = bank;
        fbWrite.addr  = addr;
        fbWrite.color = color;
    end

endmodule

`default_nettype wire

/* verilog/videoPkg.sv */
//****************************************
// videoPkg
// scan counters and video output stream
//****************************************
`default_nettype none

package videoPkg;

    typedef logic [11:0] scanPosT;

    typedef struct packed {
        logic          de;
        logic          hsync;       // high in horizontal blanking
        logic          vsync;       // high in vertical blanking
        logic          frameStart;  // marks first pixel of a frame
        gpuPkg::pixelT rgb;
    } videoOutT;

endpackage

`default_nettype wire

/* verilog/videoScan.sv */
//****************************************
// videoScan
// scan timing, pixel fetch and output stream
//****************************************
`timescale 1ns/1ps
`default_nettype none

module videoScan
#(
    parameter int hDisp  = 16,
    parameter int vDisp  = 8,
    parameter int hBlank = 4,
    parameter int vBlank = 2
)
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               displayBank,
    output logic               frameStart,
    output logic               rdBank,
    output gpuPkg::fbAddrT     rdAddr,
    input  gpuPkg::pixelT      rdData,
    output videoPkg::videoOutT video
);

    localparam videoPkg::scanPosT hLast   = videoPkg::scanPosT'(hDisp + hBlank - 1);
    localparam videoPkg::scanPosT vLast   = videoPkg::scanPosT'(vDisp + vBlank - 1);
    localparam videoPkg::scanPosT hActive = videoPkg::scanPosT'(hDisp);
    localparam videoPkg::scanPosT vActive = videoPkg::scanPosT'(vDisp);

    videoPkg::scanPosT hCnt;
    videoPkg::scanPosT vCnt;
    logic              active;
    logic              firstPix;
    logic              deD;         // stage aligned with rdData
    logic              hsyncD;
    logic              vsyncD;
    logic              firstPixD;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hCnt <= '0;
            vCnt <= '0;
        end
        else if (hCnt == hLast)
        begin
            hCnt <= '0;
            vCnt <= (vCnt == vLast) ? '0 : vCnt + 1'b1;
        end
        else
        begin
            hCnt <= hCnt + 1'b1;
        end
    end

    assign active   = (hCnt < hActive) && (vCnt < vActive);
    assign firstPix = (hCnt == '0) && (vCnt == '0);

    // pulses on the last cycle of a frame so the bank switch lands on pixel 0
    assign frameStart = (hCnt == hLast) && (vCnt == vLast);

    assign rdBank = displayBank;
    assign rdAddr = active ? gpuPkg::fbAddrT'(32'(vCnt) * 32'(hDisp) + 32'(hCnt)) : '0;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            deD       <= 1'b0;
            hsyncD    <= 1'b0;
            vsyncD    <= 1'b0;
            firstPixD <= 1'b0;
            video     <= '0;
        end
        else
        begin
            deD       <= active;
            hsyncD    <= (hCnt >= hActive);
            vsyncD    <= (vCnt >= vActive);
            firstPixD <= firstPix;

            video.de         <= deD;
            video.hsync      <= hsyncD;
            video.vsync      <= vsyncD;
            video.frameStart <= firstPixD;
            video.rgb        <= deD ? rdData : '0;   // black in blanking
        end
    end

endmodule

`default_nettype wire
